/* vector_decode.f */
+incdir+test
hw/vdec_pkg.sv
hw/pipe_stage.sv
hw/opi_decoder.sv
hw/opm_decoder.sv
hw/vctrl_combine.sv
hw/vector_decode_unit.sv
test/tb_vector_decode_unit.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the vector decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f vector_decode.f \
  --top-module tb_vector_decode_unit \
  -o sim_vector_decode
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_vector_decode
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

exit 0

/* test/vdec_tb_table.svh */
/*
 * Decode table for the vector decode testbench
 * One row per instruction word with the control fields it should
 * produce. Register fields and vm are randomised when a row is sent.
 */
`ifndef VDEC_TB_TABLE_SVH
`define VDEC_TB_TABLE_SVH

localparam int NUM_ROWS = 56;
// shorthand for one-bit expected fields
localparam logic T = 1'b1;
localparam logic F = 1'b0;

typedef struct packed {
  instr_t instr;
  logic   legal;
  fu_t    fu_type;
  valu_t  aluop;
  logic   is_signed;
  src_t   rs1_type;
  src_t   rs2_type;
  cfg_t   cfgsel;
  logic   vreg_wen;
  logic   rd_scalar;
  logic   single_bit_op;
} row_t;

row_t rows [NUM_ROWS];

function automatic row_t make_row(input instr_t instr, input logic legal, input fu_t fu,
                                  input valu_t alu, input logic sgn, input src_t rs1,
                                  input src_t rs2, input cfg_t cfg, input logic wen,
                                  input logic rds, input logic sbo);
  return '{instr, legal, fu, alu, sgn, rs1, rs2, cfg, wen, rds, sbo};
endfunction

// illegal words keep nothing but the register fields
function automatic row_t illegal_row(input instr_t instr);
  return make_row(instr, F, ARITH, VALU_ADD, F, V, V, NOT_CFG, F, F, F);
endfunction

task automatic fill_table();
  rows[0]  = make_row(opv(VADD, OPIVV), T, ARITH, VALU_ADD, T, V, V, NOT_CFG, T, F, F);
  rows[1]  = make_row(opv(VADD, OPIVI), T, ARITH, VALU_ADD, T, I, V, NOT_CFG, T, F, F);
  rows[2]  = make_row(opv(VSUB, OPIVX), T, ARITH, VALU_SUB, T, X, V, NOT_CFG, T, F, F);
  rows[3]  = illegal_row(opv(VSUB, OPIVI));
  rows[4]  = make_row(opv(VRSUB, OPIVI), T, ARITH, VALU_SUB, T, I, V, NOT_CFG, T, F, F);
  rows[5]  = illegal_row(opv(VRSUB, OPIVV));
  rows[6]  = make_row(opv(VMINU, OPIVV), T, ARITH, VALU_MM, F, V, V, NOT_CFG, T, F, F);
  rows[7]  = make_row(opv(VMAX, OPIVX), T, ARITH, VALU_MM, T, X, V, NOT_CFG, T, F, F);
  rows[8]  = make_row(opv(VAND, OPIVI), T, ARITH, VALU_AND, F, I, V, NOT_CFG, T, F, F);
  rows[9]  = make_row(opv(VOR, OPIVV), T, ARITH, VALU_OR, F, V, V, NOT_CFG, T, F, F);
  rows[10] = make_row(opv(VXOR, OPIVX), T, ARITH, VALU_XOR, F, X, V, NOT_CFG, T, F, F);
  rows[11] = make_row(opv(VMSEQ, OPIVI), T, ARITH, VALU_COMP, T, I, V, NOT_CFG, T, F, T);
  rows[12] = make_row(opv(VMSLTU, OPIVX), T, ARITH, VALU_COMP, F, X, V, NOT_CFG, T, F, T);
  rows[13] = illegal_row(opv(VMSLT, OPIVI));
  rows[14] = make_row(opv(VMSGT, OPIVX), T, ARITH, VALU_COMP, T, X, V, NOT_CFG, T, F, T);
  rows[15] = illegal_row(opv(VMSGTU, OPIVV));
  rows[16] = make_row(opv(VMSLEU, OPIVV), T, ARITH, VALU_COMP, F, V, V, NOT_CFG, T, F, T);
  rows[17] = make_row(opv(VSLL, OPIVI), T, ARITH, VALU_SLL, F, I, V, NOT_CFG, T, F, F);
  rows[18] = make_row(opv(VSRL, OPIVV), T, ARITH, VALU_SRL, F, V, V, NOT_CFG, T, F, F);
  rows[19] = make_row(opv(VSRA, OPIVX), T, ARITH, VALU_SRA, F, X, V, NOT_CFG, T, F, F);
  rows[20] = make_row(opv(VREDSUM, OPMVV), T, RED, VALU_ADD, T, V, V, NOT_CFG, T, F, F);
  rows[21] = make_row(opv(VREDXOR, OPMVV), T, RED, VALU_XOR, F, V, V, NOT_CFG, T, F, F);
  rows[22] = illegal_row(opv(VREDAND, OPMVX));
  rows[23] = make_row(opv(VMUL, OPMVX), T, MUL, VALU_NONE, T, X, V, NOT_CFG, T, F, F);
  rows[24] = make_row(opv(VMULHU, OPMVV), T, MUL, VALU_NONE, F, V, V, NOT_CFG, T, F, F);
  rows[25] = make_row(opv(VMULHSU, OPMVX), T, MUL, VALU_NONE, T, X, V, NOT_CFG, T, F, F);
  rows[26] = make_row(opv(VDIV, OPMVV), T, DIV, VALU_NONE, T, V, V, NOT_CFG, T, F, F);
  rows[27] = make_row(opv(VREMU, OPMVX), T, DIV, VALU_NONE, F, X, V, NOT_CFG, T, F, F);
  rows[28] = make_row(opv(VMAND, OPMVV), T, MASK, VALU_AND, F, V, V, NOT_CFG, T, F, F);
  rows[29] = make_row(opv(VMOR, OPMVV), T, MASK, VALU_OR, F, V, V, NOT_CFG, T, F, F);
  rows[30] = illegal_row(opv(VMXOR, OPMVX));
  rows[31] = make_row(cfg_word(2'b00), T, ARITH, VALU_NONE, F, X, V, VSETVLI, F, T, F);
  rows[32] = make_row(cfg_word(2'b11), T, ARITH, VALU_NONE, F, I, V, VSETIVLI, F, T, F);
  rows[33] = make_row(cfg_word(2'b10), T, ARITH, VALU_NONE, F, X, V, VSETVL, F, T, F);
  rows[34] = make_row(mem_word(LOAD_FP, MOP_UNIT, WIDTH8), T, LOAD_UNIT, VALU_NONE,
                      F, X, V, NOT_CFG, T, F, F);
  rows[35] = make_row(mem_word(LOAD_FP, MOP_STRIDED, WIDTH32), T, LOAD_UNIT, VALU_NONE,
                      F, X, X, NOT_CFG, T, F, F);
  rows[36] = make_row(mem_word(STORE_FP, MOP_UNIT, WIDTH16), T, STORE_UNIT, VALU_NONE,
                      F, X, V, NOT_CFG, F, F, F);
  rows[37] = make_row(mem_word(STORE_FP, MOP_STRIDED, WIDTH8), T, STORE_UNIT, VALU_NONE,
                      F, X, X, NOT_CFG, F, F, F);
  // 64-bit elements are not supported
  rows[38] = illegal_row(mem_word(LOAD_FP, MOP_UNIT, 3'b111));
  // vslideup.vx and vredmax.vs are dropped groups
  rows[39] = illegal_row(opv(6'b001110, OPIVX));
  rows[40] = illegal_row(opv(6'b000111, OPMVV));
  // scalar add, then vfadd.vv from the OPFVV space
  rows[41] = illegal_row(32'h0020_81B3);
  rows[42] = illegal_row(opv(VADD, 3'b001));
  // remaining kept operations in one of their legal forms
  rows[43] = make_row(opv(VMIN, OPIVX), T, ARITH, VALU_MM, T, X, V, NOT_CFG, T, F, F);
  rows[44] = make_row(opv(VMAXU, OPIVV), T, ARITH, VALU_MM, F, V, V, NOT_CFG, T, F, F);
  rows[45] = make_row(opv(VMSNE, OPIVI), T, ARITH, VALU_COMP, T, I, V, NOT_CFG, T, F, T);
  rows[46] = make_row(opv(VMSLT, OPIVV), T, ARITH, VALU_COMP, T, V, V, NOT_CFG, T, F, T);
  rows[47] = make_row(opv(VMSLE, OPIVX), T, ARITH, VALU_COMP, T, X, V, NOT_CFG, T, F, T);
  rows[48] = make_row(opv(VMSGTU, OPIVI), T, ARITH, VALU_COMP, F, I, V, NOT_CFG, T, F, T);
  rows[49] = make_row(opv(VSUB, OPIVV), T, ARITH, VALU_SUB, T, V, V, NOT_CFG, T, F, F);
  rows[50] = make_row(opv(VREDAND, OPMVV), T, RED, VALU_AND, F, V, V, NOT_CFG, T, F, F);
  rows[51] = make_row(opv(VREDOR, OPMVV), T, RED, VALU_OR, F, V, V, NOT_CFG, T, F, F);
  rows[52] = make_row(opv(VMULH, OPMVV), T, MUL, VALU_NONE, T, V, V, NOT_CFG, T, F, F);
  rows[53] = make_row(opv(VDIVU, OPMVX), T, DIV, VALU_NONE, F, X, V, NOT_CFG, T, F, F);
  rows[54] = make_row(opv(VREM, OPMVX), T, DIV, VALU_NONE, T, X, V, NOT_CFG, T, F, F);
  rows[55] = make_row(opv(VMXOR, OPMVV), T, MASK, VALU_XOR, F, V, V, NOT_CFG, T, F, F);
endtask

`endif

/* test/tb_vector_decode_unit.sv */
/*
 * Testbench for the vector decode unit
 * Sends a table of instruction words twice, first with random input
 * gaps and output back-pressure, then at full rate. A scoreboard
 * checks every control word, its order, its hold under stall and the
 * two-cycle latency at full rate.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_vector_decode_unit;
  import vdec_pkg::*;

  localparam int CLK_PERIOD = 100;
  // randomised fields: vm, vs2, vs1 and vd
  localparam logic [31:0] REG_MASK = 32'h03FF_8F80;

  logic   clk;
  logic   reset;
  logic   in_valid;
  logic   in_ready;
  instr_t in_instr;
  logic   out_valid;
  logic   out_ready;
  vctrl_t out_ctrl;

  function automatic instr_t opv(input logic [5:0] funct6, input logic [2:0] funct3);
    return {funct6, 1'b1, 10'd0, funct3, 5'd0, VECTOR};
  endfunction

  // top two bits select vsetvli, vsetivli or vsetvl
  function automatic instr_t cfg_word(input logic [1:0] top);
    return {top, 15'd0, OPCFG, 5'd0, VECTOR};
  endfunction

  function automatic instr_t mem_word(input opcode_t opcode, input mop_t mop,
                                      input logic [2:0] width);
    return {3'd0, 1'b0, mop, 1'b1, 10'd0, width, 5'd0, opcode};
  endfunction

  `include "vdec_tb_table.svh"

  localparam int WATCHDOG_CYCLES = 2 * NUM_ROWS * 20 + 10;

  typedef struct packed {
    row_t        row;
    instr_t      word;
    logic        fast;
    logic [31:0] cycle;
  } pending_t;

  pending_t    pending [$];
  row_t        offer_row;
  instr_t      offer_word;
  logic        offer_fast;
  logic        full_rate;
  logic [31:0] gap_state;
  logic [31:0] bp_state;
  logic [31:0] cycle_count;
  logic        stalled;
  vctrl_t      held_ctrl;

  vector_decode_unit vector_decode_unit_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_instr  (in_instr),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_ctrl  (out_ctrl)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic check_field(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual == expected) else begin
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_ctrl(input pending_t entry, input vctrl_t got);
    row_t exp;
    exp = entry.row;
    check_field("legal", 64'(exp.legal), 64'(got.legal));
    check_field("fu_type", 64'(exp.fu_type), 64'(got.fu_type));
    check_field("aluop", 64'(exp.aluop), 64'(got.aluop));
    check_field("is_signed", 64'(exp.is_signed), 64'(got.is_signed));
    check_field("rs1_type", 64'(exp.rs1_type), 64'(got.rs1_type));
    check_field("rs2_type", 64'(exp.rs2_type), 64'(got.rs2_type));
    check_field("cfgsel", 64'(exp.cfgsel), 64'(got.cfgsel));
    check_field("vreg_wen", 64'(exp.vreg_wen), 64'(got.vreg_wen));
    check_field("rd_scalar", 64'(exp.rd_scalar), 64'(got.rd_scalar));
    check_field("single_bit_op", 64'(exp.single_bit_op), 64'(got.single_bit_op));
    check_field("vd", 64'(entry.word[11:7]), 64'(got.vd));
    check_field("vs1", 64'(entry.word[19:15]), 64'(got.vs1));
    check_field("vs2", 64'(entry.word[24:20]), 64'(got.vs2));
    check_field("vm", 64'(entry.word[25]), 64'(got.vm));
    if (entry.fast) begin
      check_field("latency", 64'(2), 64'(cycle_count - entry.cycle));
    end
  endtask

  // offer one row, called and returning on a falling edge
  task automatic send_row(input int idx, input logic gaps);
    instr_t word;
    gap_state = lcg_step(gap_state);
    word = (rows[idx].instr & ~REG_MASK) | (gap_state & REG_MASK);
    if (gaps) begin
      gap_state = lcg_step(gap_state);
      while (gap_state[17:16] == 2'b00) begin
        in_valid = 1'b0;
        @(negedge clk);
        gap_state = lcg_step(gap_state);
      end
    end
    offer_row  = rows[idx];
    offer_word = word;
    offer_fast = full_rate;
    in_instr   = word;
    in_valid   = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random back-pressure, always ready at full rate
  initial begin
    out_ready = 1'b0;
    bp_state  = lcg_step(32'd62);
    forever begin
      @(negedge clk);
      bp_state  = lcg_step(bp_state);
      out_ready = full_rate || bp_state[16];
    end
  end

  // scoreboard and stall monitor
  initial begin
    cycle_count  = '0;
    stalled      = 1'b0;
    held_ctrl    = '0;
    forever begin
      @(posedge clk);
      if (!reset) begin
        if (stalled) begin
          assert (out_valid) else fail_run("out_valid dropped while the output was stalled");
          check_field("out_ctrl held", 64'(held_ctrl), 64'(out_ctrl));
        end
        if (out_valid && out_ready) begin
          assert (pending.size() != 0) else fail_run("control word with no instruction sent");
          compare_ctrl(pending.pop_front(), out_ctrl);
        end
        if (in_valid && in_ready) begin
          pending.push_back('{offer_row, offer_word, offer_fast, cycle_count});
        end
        stalled   = out_valid && !out_ready;
        held_ctrl = out_ctrl;
      end
      cycle_count = cycle_count + 32'd1;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_run();
  end

  initial begin
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_instr  = '0;
    full_rate = 1'b0;
    gap_state = 32'd62;
    offer_row  = '0;
    offer_word = '0;
    offer_fast = 1'b0;
    fill_table();
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // both stages empty after reset
    assert (in_ready && !out_valid) else fail_run("pipeline not empty after reset");

    for (int i = 0; i < NUM_ROWS; i++) begin
      send_row(i, 1'b1);
    end
    in_valid = 1'b0;
    while (pending.size() != 0) begin
      @(negedge clk);
    end

    // full rate, the next falling edge sees out_ready high
    full_rate = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_ROWS; i++) begin
      send_row(i, 1'b0);
    end
    in_valid = 1'b0;
    while (pending.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/vector_decode_unit.sv */
/*
 * Vector decode unit, top level
 * Registers each instruction, decodes it through the OPI and OPM
 * decoders in parallel, merges the results into a control word and
 * registers that toward the output stream. Two cycles of latency.
 */
`timescale 1ns/10ps
`default_nettype none

module vector_decode_unit (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             in_valid,
  output logic                  in_ready,
  input  vdec_pkg::instr_t      in_instr,
  output logic                  out_valid,
  input  wire logic             out_ready,
  output vdec_pkg::vctrl_t      out_ctrl
);
  import vdec_pkg::*;

  // instruction stage to control stage link
  logic        dec_valid;
  logic        dec_ready;
  instr_t      dec_instr;
  dec_result_t opi_res;
  dec_result_t opm_res;
  vctrl_t      dec_ctrl;

  pipe_stage #(
    .payload_t (instr_t)
  ) instr_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_instr),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out_data  (dec_instr)
  );

  opi_decoder opi_decoder_inst (
    .instr  (dec_instr),
    .result (opi_res)
  );

  opm_decoder opm_decoder_inst (
    .instr  (dec_instr),
    .result (opm_res)
  );

  vctrl_combine vctrl_combine_inst (
    .instr (dec_instr),
    .opi   (opi_res),
    .opm   (opm_res),
    .ctrl  (dec_ctrl)
  );

  pipe_stage #(
    .payload_t (vctrl_t)
  ) ctrl_stage_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (dec_valid),
    .in_ready  (dec_ready),
    .in_data   (dec_ctrl),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_ctrl)
  );

endmodule

`default_nettype wire

/* hw/vctrl_combine.sv */
/*
 * Control word combiner
 * Merges the OPI and OPM decoder results with vsetvl* and vector
 * load/store detection, then derives the functional unit, ALU
 * operation and operand kinds. Illegal words carry only the register
 * fields and vm.
 */
`timescale 1ns/10ps
`default_nettype none

module vctrl_combine (
  input  vdec_pkg::instr_t      instr,
  input  vdec_pkg::dec_result_t opi,
  input  vdec_pkg::dec_result_t opm,
  output vdec_pkg::vctrl_t      ctrl
);
  import vdec_pkg::*;

  opcode_t  opcode;
  vfunct3_t funct3;
  width_t   width;
  mop_t     mop;
  cfg_t     cfg;
  vop_t     op;
  fu_t      op_fu;
  valu_t    op_alu;
  logic     op_signed;
  logic     op_compare;
  logic     any_match;
  logic     is_vector;
  logic     width_ok;
  logic     is_load;
  logic     is_store;

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = vfunct3_t'(instr[14:12]);
  assign width     = width_t'(instr[14:12]);
  assign mop       = mop_t'(instr[27:26]);
  assign is_vector = opcode == VECTOR;
  assign any_match = opi.match || opm.match;
  assign op        = opi.match ? opi.op : (opm.match ? opm.op : BAD_OP);

  // vsetvli has bit 31 clear, the other two split on bit 30
  always_comb begin
    cfg = NOT_CFG;
    if (is_vector && funct3 == OPCFG) begin
      if (!instr[31]) begin
        cfg = VSETVLI;
      end else if (instr[30]) begin
        cfg = VSETIVLI;
      end else begin
        cfg = VSETVL;
      end
    end
  end

  assign width_ok = (width == WIDTH8) || (width == WIDTH16) || (width == WIDTH32);
  assign is_load  = (opcode == LOAD_FP) && width_ok;
  assign is_store = (opcode == STORE_FP) && width_ok;

  // per-operation attributes
  always_comb begin
    case (op)
      OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR: op_fu = RED;
      OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:      op_fu = MUL;
      OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:          op_fu = DIV;
      OP_VMAND, OP_VMOR, OP_VMXOR:                   op_fu = MASK;
      default:                                       op_fu = ARITH;
    endcase
    case (op)
      OP_VADD, OP_VREDSUM:                           op_alu = VALU_ADD;
      OP_VSUB, OP_VRSUB:                             op_alu = VALU_SUB;
      OP_VAND, OP_VREDAND, OP_VMAND:                 op_alu = VALU_AND;
      OP_VOR, OP_VREDOR, OP_VMOR:                    op_alu = VALU_OR;
      OP_VXOR, OP_VREDXOR, OP_VMXOR:                 op_alu = VALU_XOR;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT:      op_alu = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX:          op_alu = VALU_MM;
      OP_VSLL:                                       op_alu = VALU_SLL;
      OP_VSRL:                                       op_alu = VALU_SRL;
      OP_VSRA:                                       op_alu = VALU_SRA;
      default:                                       op_alu = VALU_NONE;
    endcase
  end

  assign op_compare = op_alu == VALU_COMP;

  always_comb begin
    case (op)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM, OP_VMUL, OP_VMULH,
      OP_VMULHSU, OP_VDIV, OP_VREM: op_signed = 1'b1;
      default:                      op_signed = 1'b0;
    endcase
  end

  always_comb begin
    ctrl     = '0;
    ctrl.vd  = instr[11:7];
    ctrl.vs1 = instr[19:15];
    ctrl.vs2 = instr[24:20];
    ctrl.vm  = instr[25];
    if (any_match) begin
      ctrl.legal         = 1'b1;
      ctrl.fu_type       = op_fu;
      ctrl.aluop         = op_alu;
      ctrl.is_signed     = op_signed;
      ctrl.single_bit_op = op_compare;
      // every decoded operation writes a vector destination
      ctrl.vreg_wen      = 1'b1;
      if (funct3 == OPIVX || funct3 == OPMVX) begin
        ctrl.rs1_type = X;
      end else if (funct3 == OPIVI) begin
        ctrl.rs1_type = I;
      end
    end else if (cfg != NOT_CFG) begin
      ctrl.legal     = 1'b1;
      ctrl.aluop     = VALU_NONE;
      ctrl.cfgsel    = cfg;
      ctrl.rd_scalar = 1'b1;
      ctrl.rs1_type  = (cfg == VSETIVLI) ? I : X;
    end else if (is_load || is_store) begin
      ctrl.legal    = 1'b1;
      ctrl.fu_type  = is_load ? LOAD_UNIT : STORE_UNIT;
      ctrl.aluop    = VALU_NONE;
      ctrl.rs1_type = X;
      // base plus stride, both from the scalar file
      ctrl.rs2_type = (mop == MOP_STRIDED) ? X : V;
      ctrl.vreg_wen = is_load;
    end
  end

  // funct3 spaces are disjoint, so at most one decoder can claim a word
  always_comb begin
    decoders_exclusive: assert final (!(opi.match && opm.match));
    unit_needs_source: assert final (
      (ctrl.fu_type == ARITH) || any_match || is_load || is_store || !ctrl.legal);
  end

endmodule

`default_nettype wire

/* hw/opm_decoder.sv */
/*
 * OPM operation decoder
 * Decodes funct6 of OP-V instructions in the OPMVV and OPMVX
 * categories: reductions, multiply, divide/remainder and mask logic.
 */
`timescale 1ns/10ps
`default_nettype none

module opm_decoder (
  input  vdec_pkg::instr_t      instr,
  output vdec_pkg::dec_result_t result
);
  import vdec_pkg::*;

  // allowed forms as {vx, vv}
  localparam logic [1:0] FORM_VV    = 2'b01;
  localparam logic [1:0] FORM_VV_VX = 2'b11;

  vopm_t      funct6;
  vfunct3_t   funct3;
  vop_t       cand;
  logic [1:0] form;
  logic [1:0] allow;
  logic       is_vector;
  logic       hit;

  assign funct6    = vopm_t'(instr[31:26]);
  assign funct3    = vfunct3_t'(instr[14:12]);
  assign is_vector = opcode_t'(instr[6:0]) == VECTOR;
  assign form      = {funct3 == OPMVX, funct3 == OPMVV};

  always_comb begin
    case (funct6)
      VREDSUM: cand = OP_VREDSUM;
      VREDAND: cand = OP_VREDAND;
      VREDOR:  cand = OP_VREDOR;
      VREDXOR: cand = OP_VREDXOR;
      VMUL:    cand = OP_VMUL;
      VMULH:   cand = OP_VMULH;
      VMULHU:  cand = OP_VMULHU;
      VMULHSU: cand = OP_VMULHSU;
      VDIVU:   cand = OP_VDIVU;
      VDIV:    cand = OP_VDIV;
      VREMU:   cand = OP_VREMU;
      VREM:    cand = OP_VREM;
      VMAND:   cand = OP_VMAND;
      VMOR:    cand = OP_VMOR;
      VMXOR:   cand = OP_VMXOR;
      default: cand = BAD_OP;
    endcase
  end

  // reductions and mask logicals read vector sources only
  always_comb begin
    case (funct6)
      VREDSUM, VREDAND, VREDOR, VREDXOR: allow = FORM_VV;
      VMAND, VMOR, VMXOR:                allow = FORM_VV;
      default:                           allow = FORM_VV_VX;
    endcase
  end

  assign hit = is_vector && (cand != BAD_OP) && |(form & allow);

  assign result.match = hit;
  assign result.op    = hit ? cand : BAD_OP;

endmodule

`default_nettype wire

/* hw/opi_decoder.sv */
/*
 * OPI operation decoder
 * Decodes funct6 of OP-V instructions in the OPIVV, OPIVX and OPIVI
 * categories. Reports a match only for kept operations in an
 * operand form that the operation supports.
 */
`timescale 1ns/10ps
`default_nettype none

module opi_decoder (
  input  vdec_pkg::instr_t      instr,
  output vdec_pkg::dec_result_t result
);
  import vdec_pkg::*;

  // allowed forms as {vi, vx, vv}
  localparam logic [2:0] FORM_ALL   = 3'b111;
  localparam logic [2:0] FORM_VV_VX = 3'b011;
  localparam logic [2:0] FORM_VX_VI = 3'b110;

  vopi_t      funct6;
  vfunct3_t   funct3;
  vop_t       cand;
  logic [2:0] form;
  logic [2:0] allow;
  logic       is_vector;
  logic       hit;

  assign funct6    = vopi_t'(instr[31:26]);
  assign funct3    = vfunct3_t'(instr[14:12]);
  assign is_vector = opcode_t'(instr[6:0]) == VECTOR;
  assign form      = {funct3 == OPIVI, funct3 == OPIVX, funct3 == OPIVV};

  always_comb begin
    case (funct6)
      VADD:    cand = OP_VADD;
      VSUB:    cand = OP_VSUB;
      VRSUB:   cand = OP_VRSUB;
      VMINU:   cand = OP_VMINU;
      VMIN:    cand = OP_VMIN;
      VMAXU:   cand = OP_VMAXU;
      VMAX:    cand = OP_VMAX;
      VAND:    cand = OP_VAND;
      VOR:     cand = OP_VOR;
      VXOR:    cand = OP_VXOR;
      VMSEQ:   cand = OP_VMSEQ;
      VMSNE:   cand = OP_VMSNE;
      VMSLTU:  cand = OP_VMSLTU;
      VMSLT:   cand = OP_VMSLT;
      VMSLEU:  cand = OP_VMSLEU;
      VMSLE:   cand = OP_VMSLE;
      VMSGTU:  cand = OP_VMSGTU;
      VMSGT:   cand = OP_VMSGT;
      VSLL:    cand = OP_VSLL;
      VSRL:    cand = OP_VSRL;
      VSRA:    cand = OP_VSRA;
      default: cand = BAD_OP;
    endcase
  end

  // no immediate form for these
  always_comb begin
    case (funct6)
      VSUB, VMINU, VMIN, VMAXU, VMAX, VMSLTU, VMSLT: allow = FORM_VV_VX;
      // reverse forms only, vv would alias another compare
      VRSUB, VMSGTU, VMSGT:                          allow = FORM_VX_VI;
      default:                                       allow = FORM_ALL;
    endcase
  end

  assign hit = is_vector && (cand != BAD_OP) && |(form & allow);

  assign result.match = hit;
  assign result.op    = hit ? cand : BAD_OP;

endmodule

`default_nettype wire

/* hw/pipe_stage.sv */
/*
 * Pipeline register stage
 * One-entry valid/ready slot. The payload type is a parameter so the
 * same stage carries instructions or control words. Accepts new data
 * when empty or when the current entry leaves in the same cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     in_valid,
  output logic          in_ready,
  input  payload_t      in_data,
  output logic          out_valid,
  input  wire logic     out_ready,
  output payload_t      out_data
);

  logic     valid_q;
  payload_t data_q;

  // slot frees up in the same cycle it drains
  assign in_ready = !valid_q || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

  // a stalled entry must not change under back-pressure
  hold_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  );

endmodule

`default_nettype wire

/* hw/vdec_pkg.sv */
/*
 * Vector decoder shared definitions
 * Holds the RVV 1.0 opcode, funct3 and funct6 encodings used by the
 * decoder, the internal operation list, and the packed control word
 * returned for every instruction.
 */
`default_nettype none

package vdec_pkg;

  parameter int INSTR_W   = 32;
  parameter int REG_IDX_W = 5;

  typedef logic [INSTR_W-1:0] instr_t;

  // major opcodes, architectural assignment
  typedef enum logic [6:0] {
    VECTOR   = 7'b1010111,
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111
  } opcode_t;

  // operand category in funct3 of OP-V
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // element widths supported by vector loads and stores
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  typedef enum logic [1:0] {
    MOP_UNIT    = 2'b00,
    MOP_UINDEX  = 2'b01,
    MOP_STRIDED = 2'b10,
    MOP_OINDEX  = 2'b11
  } mop_t;

  // funct6 for the integer operand space
  typedef enum logic [5:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  // funct6 for the OPM space
  typedef enum logic [5:0] {
    VREDSUM = 6'b000000,
    VREDAND = 6'b000001,
    VREDOR  = 6'b000010,
    VREDXOR = 6'b000011,
    VMAND   = 6'b011001,
    VMOR    = 6'b011010,
    VMXOR   = 6'b011011,
    VDIVU   = 6'b100000,
    VDIV    = 6'b100001,
    VREMU   = 6'b100010,
    VREM    = 6'b100011,
    VMULHU  = 6'b100100,
    VMUL    = 6'b100101,
    VMULHSU = 6'b100110,
    VMULH   = 6'b100111
  } vopm_t;

  // decoded operation, BAD_OP when nothing matched
  typedef enum logic [5:0] {
    BAD_OP,
    OP_VADD, OP_VSUB, OP_VRSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT, OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VMAND, OP_VMOR, OP_VMXOR
  } vop_t;

  typedef struct packed {
    logic match;
    vop_t op;
  } dec_result_t;

  typedef enum logic [2:0] {ARITH, RED, MUL, DIV, MASK, LOAD_UNIT, STORE_UNIT} fu_t;

  typedef enum logic [3:0] {
    VALU_ADD, VALU_SUB, VALU_AND, VALU_OR, VALU_XOR, VALU_COMP,
    VALU_MM, VALU_SLL, VALU_SRL, VALU_SRA, VALU_NONE
  } valu_t;

  typedef enum logic [1:0] {V, X, I} src_t;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfg_t;

  typedef struct packed {
    logic                 legal;
    fu_t                  fu_type;
    valu_t                aluop;
    logic                 is_signed;
    src_t                 rs1_type;
    src_t                 rs2_type;
    cfg_t                 cfgsel;
    logic                 vreg_wen;
    logic                 rd_scalar;
    logic                 single_bit_op;
    logic [REG_IDX_W-1:0] vd;
    logic [REG_IDX_W-1:0] vs1;
    logic [REG_IDX_W-1:0] vs2;
    logic                 vm;
  } vctrl_t;

endpackage

`default_nettype wire
